// ==== source/arenaPkg.sv ====
package arenaPkg;

	typedef logic [12:0] busAddr;        // CPU word address
	typedef logic [11:0] memAddr;        // Data memory index
	typedef logic [4:0] regField;        // Block or register number
	typedef logic [31:0] dataWord;       // Bus data and register width
	typedef logic signed [15:0] coord;   // One signed axis
	typedef logic [31:0] point;          // x high, y low, y grows down
	typedef logic [3:0] contactFlags;    // Floor, ceiling, left, right
	typedef logic [63:0] spriteWord;     // Position high, size low

	localparam int kPlayers = 2;
	localparam int kMemDepth = 4096;

	// Bus address fields
	localparam int kRegionBit = 12;      // Set for coprocessors
	localparam int kBlockMsb = 11;
	localparam int kBlockLsb = 7;
	localparam int kRegMsb = 6;
	localparam int kRegLsb = 2;

	// Block numbers
	localparam regField kBlockPlayer0 = 5'd0;
	localparam regField kBlockPlayer1 = 5'd1;
	localparam regField kBlockStage = 5'd2;

	// Player registers
	localparam regField kRegGravity = 5'd0;  // Reads back position
	localparam regField kRegStart = 5'd1;    // Reads back position
	localparam regField kRegControl = 5'd2;  // Reads back contact flags
	localparam regField kRegSize = 5'd3;

	// Stage registers
	localparam regField kRegStagePos = 5'd0;
	localparam regField kRegStageSize = 5'd1;

	// Controller word bits
	localparam int kCtrlLeft = 0;
	localparam int kCtrlRight = 1;
	localparam int kCtrlJump = 2;

	// Contact flag bits
	localparam int kFloor = 0;
	localparam int kCeiling = 1;
	localparam int kLeftWall = 2;
	localparam int kRightWall = 3;

	// Motion, pixels per frame tick
	localparam coord kWalkSpeed = 16'sd4;
	localparam coord kJumpSpeed = 16'sd12;

endpackage

// ==== source/dataMemory.sv ====
module dataMemory (
	input  logic              clock,
	input  arenaPkg::memAddr  address,
	input  arenaPkg::dataWord writeData,
	input  logic              writeEnable,
	output arenaPkg::dataWord readData
);
	import arenaPkg::*;

	dataWord mem [kMemDepth];   // CPU data words

	always_ff @(posedge clock) begin
		readData <= mem[address];   // Old word on a write cycle
		if (writeEnable) begin
			mem[address] <= writeData;
		end
	end

endmodule

// ==== source/busRegisters.sv ====
module busRegisters (
	input  logic                  clock,
	input  logic                  reset,
	input  arenaPkg::busAddr      address,
	input  arenaPkg::dataWord     writeData,
	input  logic                  writeEnable,
	input  arenaPkg::dataWord     memData,
	input  arenaPkg::point        position0,
	input  arenaPkg::point        position1,
	input  arenaPkg::contactFlags contact0,
	input  arenaPkg::contactFlags contact1,
	output arenaPkg::dataWord     readData,
	output logic                  memWrite,
	output arenaPkg::coord        gravity0,
	output arenaPkg::coord        gravity1,
	output arenaPkg::dataWord     control0,
	output arenaPkg::dataWord     control1,
	output arenaPkg::point        size0,
	output arenaPkg::point        size1,
	output logic                  startLoad0,
	output logic                  startLoad1,
	output arenaPkg::point        startPos,
	output arenaPkg::point        stagePos,
	output arenaPkg::point        stageSize
);
	import arenaPkg::*;

	regField blockSel;                    // Address bits 11..7
	regField regSel;                      // Address bits 6..2
	logic coprocWrite;
	logic stageSel;
	logic playerSel [kPlayers];
	point positionArr [kPlayers];
	contactFlags contactArr [kPlayers];
	coord gravityQ [kPlayers];
	dataWord controlQ [kPlayers];
	point sizeQ [kPlayers];
	logic startLoadQ [kPlayers];
	dataWord coprocRead;
	dataWord coprocReadQ;
	logic regionQ;                        // Region of last cycle's address

	assign blockSel = address[kBlockMsb:kBlockLsb];
	assign regSel = address[kRegMsb:kRegLsb];
	assign coprocWrite = writeEnable & address[kRegionBit];
	assign memWrite = writeEnable & ~address[kRegionBit];   // Low half only

	assign playerSel[0] = address[kRegionBit] && (blockSel == kBlockPlayer0);
	assign playerSel[1] = address[kRegionBit] && (blockSel == kBlockPlayer1);
	assign stageSel = address[kRegionBit] && (blockSel == kBlockStage);

	assign positionArr[0] = position0;
	assign positionArr[1] = position1;
	assign contactArr[0] = contact0;
	assign contactArr[1] = contact1;

	// Coprocessor register file
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int p = 0; p < kPlayers; p++) begin
				gravityQ[p] <= '0;
				controlQ[p] <= '0;
				sizeQ[p] <= '0;
				startLoadQ[p] <= 1'b0;
			end
			startPos <= '0;
			stagePos <= '0;
			stageSize <= '0;
		end else begin
			for (int p = 0; p < kPlayers; p++) begin
				startLoadQ[p] <= 1'b0;        // One-cycle pulse
				if (coprocWrite && playerSel[p]) begin
					case (regSel)
						kRegGravity: gravityQ[p] <= writeData[15:0];
						kRegStart: begin
							startPos <= writeData;      // Shared by both players
							startLoadQ[p] <= 1'b1;
						end
						kRegControl: controlQ[p] <= writeData;
						kRegSize: sizeQ[p] <= writeData;
						default: ;                    // Undefined slot ignored
					endcase
				end
			end
			if (coprocWrite && stageSel) begin
				case (regSel)
					kRegStagePos: stagePos <= writeData;
					kRegStageSize: stageSize <= writeData;
					default: ;
				endcase
			end
		end
	end

	// Readback, zero unless a readable player register
	always_comb begin
		coprocRead = '0;
		for (int p = 0; p < kPlayers; p++) begin
			if (playerSel[p]) begin
				case (regSel)
					kRegGravity, kRegStart: coprocRead = positionArr[p];
					kRegControl: coprocRead = dataWord'(contactArr[p]);
					default: coprocRead = '0;     // Size is write-only
				endcase
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			regionQ <= 1'b1;                  // Zero readback out of reset
			coprocReadQ <= '0;
		end else begin
			regionQ <= address[kRegionBit];
			coprocReadQ <= coprocRead;
		end
	end

	assign readData = regionQ ? coprocReadQ : memData;   // Lines up with memory latency

	assign gravity0 = gravityQ[0];
	assign gravity1 = gravityQ[1];
	assign control0 = controlQ[0];
	assign control1 = controlQ[1];
	assign size0 = sizeQ[0];
	assign size1 = sizeQ[1];
	assign startLoad0 = startLoadQ[0];
	assign startLoad1 = startLoadQ[1];

endmodule

// ==== source/physicsStage.sv ====
module physicsStage (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  frameTick,
	input  logic                  startLoad0,
	input  logic                  startLoad1,
	input  arenaPkg::point        startPos,
	input  arenaPkg::coord        gravity0,
	input  arenaPkg::coord        gravity1,
	input  arenaPkg::dataWord     control0,
	input  arenaPkg::dataWord     control1,
	input  arenaPkg::contactFlags contact0,
	input  arenaPkg::contactFlags contact1,
	output arenaPkg::point        position0,
	output arenaPkg::point        position1
);
	import arenaPkg::*;

	logic startLoadArr [kPlayers];
	coord gravityArr [kPlayers];
	dataWord controlArr [kPlayers];
	contactFlags contactArr [kPlayers];   // Registered last cycle by scene stage
	point positionArr [kPlayers];

	assign startLoadArr[0] = startLoad0;
	assign startLoadArr[1] = startLoad1;
	assign gravityArr[0] = gravity0;
	assign gravityArr[1] = gravity1;
	assign controlArr[0] = control0;
	assign controlArr[1] = control1;
	assign contactArr[0] = contact0;
	assign contactArr[1] = contact1;

	for (genvar p = 0; p < kPlayers; p++) begin : gPlayer
		coord velY;
		coord posX;
		coord posY;
		coord walkVel;                        // From left/right buttons
		coord fallVel;                        // Old vertical plus gravity
		coord nextVelX;
		coord nextVelY;
		logic onFloor;

		assign onFloor = contactArr[p][kFloor];
		assign fallVel = velY + gravityArr[p];

		always_comb begin
			case ({controlArr[p][kCtrlRight], controlArr[p][kCtrlLeft]})
				2'b10: walkVel = kWalkSpeed;
				2'b01: walkVel = -kWalkSpeed;
				default: walkVel = '0;            // None or both pressed
			endcase
			nextVelX = walkVel;
			if ((walkVel < 0) && contactArr[p][kLeftWall]) begin
				nextVelX = '0;                    // Blocked by left wall
			end
			if ((walkVel > 0) && contactArr[p][kRightWall]) begin
				nextVelX = '0;                    // Blocked by right wall
			end
		end

		always_comb begin
			if (onFloor && controlArr[p][kCtrlJump]) begin
				nextVelY = -kJumpSpeed;           // Jump only off the floor
			end else if (onFloor && (fallVel > 0)) begin
				nextVelY = '0;                    // No sinking while standing
			end else begin
				nextVelY = fallVel;
			end
		end

		always_ff @(posedge clock) begin
			if (reset) begin
				velY <= '0;
				posX <= '0;
				posY <= '0;
			end else if (startLoadArr[p]) begin   // Wins over a tick
				velY <= '0;
				posX <= startPos[31:16];
				posY <= startPos[15:0];
			end else if (frameTick) begin
				velY <= nextVelY;
				posX <= posX + nextVelX;          // Wraps at 16 bits
				posY <= posY + nextVelY;
			end
		end

		assign positionArr[p] = {posX, posY};
	end

	assign position0 = positionArr[0];
	assign position1 = positionArr[1];

endmodule

// ==== source/sceneStage.sv ====
module sceneStage (
	input  logic                  clock,
	input  logic                  reset,
	input  arenaPkg::point        position0,
	input  arenaPkg::point        position1,
	input  arenaPkg::point        size0,
	input  arenaPkg::point        size1,
	input  arenaPkg::point        stagePos,
	input  arenaPkg::point        stageSize,
	output arenaPkg::contactFlags contact0,
	output arenaPkg::contactFlags contact1,
	output arenaPkg::spriteWord   p1Sprite,
	output arenaPkg::spriteWord   p2Sprite,
	output arenaPkg::spriteWord   stageSprite
);
	import arenaPkg::*;

	// Contact of one player box against the stage box
	function automatic contactFlags touch(point body, point bodySize, point box,
			point boxSize);
		coord bodyLeft;
		coord bodyTop;
		coord bodyRight;
		coord bodyBottom;
		coord boxLeft;
		coord boxTop;
		coord boxRight;
		coord boxBottom;
		logic overlap;
		contactFlags flags;

		bodyLeft = body[31:16];
		bodyTop = body[15:0];
		bodyRight = bodyLeft + coord'(bodySize[31:16]);
		bodyBottom = bodyTop + coord'(bodySize[15:0]);
		boxLeft = box[31:16];
		boxTop = box[15:0];
		boxRight = boxLeft + coord'(boxSize[31:16]);
		boxBottom = boxTop + coord'(boxSize[15:0]);

		overlap = (bodyLeft < boxRight) && (bodyRight > boxLeft) &&
			(bodyTop < boxBottom) && (bodyBottom > boxTop);   // Strict, edges touching is clear

		flags = '0;
		flags[kFloor] = overlap && (bodyTop < boxTop);
		flags[kCeiling] = overlap && (bodyBottom > boxBottom);
		flags[kLeftWall] = overlap && (bodyLeft < boxLeft);
		flags[kRightWall] = overlap && (bodyRight > boxRight);
		return flags;
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			contact0 <= '0;
			contact1 <= '0;
			p1Sprite <= '0;
			p2Sprite <= '0;
			stageSprite <= '0;
		end else begin
			contact0 <= touch(position0, size0, stagePos, stageSize);
			contact1 <= touch(position1, size1, stagePos, stageSize);
			p1Sprite <= {position0, size0};       // Display word
			p2Sprite <= {position1, size1};
			stageSprite <= {stagePos, stageSize};
		end
	end

endmodule

// ==== source/arenaCore.sv ====
module arenaCore (
	input  logic                clock,
	input  logic                reset,
	input  arenaPkg::busAddr    address,
	input  arenaPkg::dataWord   writeData,
	input  logic                writeEnable,
	input  logic                frameTick,
	output arenaPkg::dataWord   readData,
	output arenaPkg::spriteWord p1Sprite,
	output arenaPkg::spriteWord p2Sprite,
	output arenaPkg::spriteWord stageSprite
);
	import arenaPkg::*;

	dataWord memData;                     // Registered memory word
	logic memWrite;
	coord gravity0;
	coord gravity1;
	dataWord control0;
	dataWord control1;
	point size0;
	point size1;
	logic startLoad0;
	logic startLoad1;
	point startPos;
	point stagePos;
	point stageSize;
	point position0;
	point position1;
	contactFlags contact0;                // Fed back to physics
	contactFlags contact1;

	dataMemory memory (
		.clock       (clock),
		.address     (address[11:0]),     // Word index within the low region
		.writeData   (writeData),
		.writeEnable (memWrite),
		.readData    (memData)
	);

	busRegisters registers (
		.clock       (clock),
		.reset       (reset),
		.address     (address),
		.writeData   (writeData),
		.writeEnable (writeEnable),
		.memData     (memData),
		.position0   (position0),
		.position1   (position1),
		.contact0    (contact0),
		.contact1    (contact1),
		.readData    (readData),
		.memWrite    (memWrite),
		.gravity0    (gravity0),
		.gravity1    (gravity1),
		.control0    (control0),
		.control1    (control1),
		.size0       (size0),
		.size1       (size1),
		.startLoad0  (startLoad0),
		.startLoad1  (startLoad1),
		.startPos    (startPos),
		.stagePos    (stagePos),
		.stageSize   (stageSize)
	);

	physicsStage physics (
		.clock      (clock),
		.reset      (reset),
		.frameTick  (frameTick),
		.startLoad0 (startLoad0),
		.startLoad1 (startLoad1),
		.startPos   (startPos),
		.gravity0   (gravity0),
		.gravity1   (gravity1),
		.control0   (control0),
		.control1   (control1),
		.contact0   (contact0),
		.contact1   (contact1),
		.position0  (position0),
		.position1  (position1)
	);

	sceneStage scene (
		.clock       (clock),
		.reset       (reset),
		.position0   (position0),
		.position1   (position1),
		.size0       (size0),
		.size1       (size1),
		.stagePos    (stagePos),
		.stageSize   (stageSize),
		.contact0    (contact0),
		.contact1    (contact1),
		.p1Sprite    (p1Sprite),
		.p2Sprite    (p2Sprite),
		.stageSprite (stageSprite)
	);

endmodule

// ==== bench/clockGen.sv ====
module clockGen (
	output logic clock,
	output logic reset
);
	localparam int kHalfPeriod = 20;     // 40 unit period
	localparam int kResetCycles = 16;

	initial begin
		clock = 1'b0;
		forever #kHalfPeriod clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (kResetCycles) @(posedge clock);
		reset <= 1'b0;                    // Released on a rising edge
	end

endmodule

// ==== bench/arenaTb.sv ====
module arenaTb;
	import arenaPkg::*;

	typedef enum {opWrite, opRead, opTick, opSprite} opKind;

	localparam int kMaxEntries = 80;
	localparam int kResetCycles = 16;
	localparam int kTimeoutMargin = 50;

	logic clock;
	logic reset;
	busAddr address;
	dataWord writeData;
	logic writeEnable;
	logic frameTick;
	dataWord readData;
	spriteWord p1Sprite;
	spriteWord p2Sprite;
	spriteWord stageSprite;

	opKind opTab [kMaxEntries];          // Stimulus and expected table
	busAddr addrTab [kMaxEntries];       // Sprite number for sprite checks
	dataWord dataTab [kMaxEntries];
	spriteWord expTab [kMaxEntries];
	string nameTab [kMaxEntries];
	dataWord shadow [kMemDepth];         // Mirror of data memory
	int entryCount = 0;
	int checkCount = 0;
	int errorCount = 0;
	int cycleCount = 0;
	int cycleLimit = 0;

	clockGen clocks (.clock(clock), .reset(reset));

	arenaCore UUT (
		.clock       (clock),
		.reset       (reset),
		.address     (address),
		.writeData   (writeData),
		.writeEnable (writeEnable),
		.frameTick   (frameTick),
		.readData    (readData),
		.p1Sprite    (p1Sprite),
		.p2Sprite    (p2Sprite),
		.stageSprite (stageSprite)
	);

	function automatic dataWord lcgNext(dataWord state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic busAddr coprocAddr(regField block, regField regNum);
		return {1'b1, block, regNum, 2'b00};
	endfunction

	task automatic checkWord(string name, dataWord expected, dataWord actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("error %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic checkContact(string name, contactFlags expected, contactFlags actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("error %s expected %b actual %b", name, expected, actual);
		end
	endtask

	task automatic checkSprite(string name, spriteWord expected, spriteWord actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("error %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic addEntry(string name, opKind op, busAddr addr, dataWord data,
			spriteWord expected);
		nameTab[entryCount] = name;
		opTab[entryCount] = op;
		addrTab[entryCount] = addr;
		dataTab[entryCount] = data;
		expTab[entryCount] = expected;
		entryCount++;
	endtask

	// Expected values worked out by hand from the physics and contact rules
	task automatic buildTable();
		dataWord state;
		memAddr picks [5];
		busAddr p0Grav;
		busAddr p0Start;
		busAddr p0Ctrl;
		busAddr p1Start;

		state = 32'hfd6b;
		picks = '{12'h000, 12'h110, 12'h180, 12'h7ff, 12'hfff};
		p0Grav = coprocAddr(kBlockPlayer0, kRegGravity);
		p0Start = coprocAddr(kBlockPlayer0, kRegStart);
		p0Ctrl = coprocAddr(kBlockPlayer0, kRegControl);
		p1Start = coprocAddr(kBlockPlayer1, kRegStart);

		// Everything zero after reset
		addEntry("resetPos0", opRead, p0Grav, 32'h0, 64'h0);
		addEntry("resetContact0", opRead, p0Ctrl, 32'h0, 64'h0);
		addEntry("resetContact1", opRead, coprocAddr(kBlockPlayer1, kRegControl), 32'h0, 64'h0);
		addEntry("resetSprite0", opSprite, 13'd0, 32'h0, 64'h0);
		addEntry("resetSprite1", opSprite, 13'd1, 32'h0, 64'h0);
		addEntry("resetStage", opSprite, 13'd2, 32'h0, 64'h0);

		// Memory words then undefined coprocessor writes aliasing 0x110 and 0x180
		foreach (picks[k]) begin
			state = lcgNext(state);
			shadow[picks[k]] = state;
			addEntry($sformatf("memWrite%0d", k), opWrite, {1'b0, picks[k]}, state, 64'h0);
		end
		state = lcgNext(state);
		addEntry("undefStageWrite", opWrite, coprocAddr(kBlockStage, 5'd4), state, 64'h0);
		state = lcgNext(state);
		addEntry("undefBlockWrite", opWrite, coprocAddr(5'd3, 5'd0), state, 64'h0);
		foreach (picks[k]) begin
			addEntry($sformatf("memRead%0d", k), opRead, {1'b0, picks[k]}, 32'h0,
				spriteWord'(shadow[picks[k]]));
		end
		addEntry("undefStageRead", opRead, coprocAddr(kBlockStage, 5'd4), 32'h0, 64'h0);
		addEntry("undefBlockRead", opRead, coprocAddr(5'd3, 5'd0), 32'h0, 64'h0);

		// Stage box x 100..300 y 200..240 with players 16x16 at (20,0) and 8x8 at (400,0)
		addEntry("stagePos", opWrite, coprocAddr(kBlockStage, kRegStagePos), 32'h006400c8, 64'h0);
		addEntry("stageSize", opWrite, coprocAddr(kBlockStage, kRegStageSize), 32'h00c80028,
			64'h0);
		addEntry("size0", opWrite, coprocAddr(kBlockPlayer0, kRegSize), 32'h00100010, 64'h0);
		addEntry("size1", opWrite, coprocAddr(kBlockPlayer1, kRegSize), 32'h00080008, 64'h0);
		addEntry("start0", opWrite, p0Start, 32'h00140000, 64'h0);
		addEntry("start1", opWrite, p1Start, 32'h01900000, 64'h0);
		addEntry("stageSprite", opSprite, 13'd2, 32'h0, 64'h006400c8_00c80028);
		addEntry("startSprite0", opSprite, 13'd0, 32'h0, 64'h00140000_00100010);
		addEntry("startSprite1", opSprite, 13'd1, 32'h0, 64'h01900000_00080008);
		addEntry("startRead0", opRead, p0Start, 32'h0, 64'h00140000);
		addEntry("startRead1", opRead, p1Start, 32'h0, 64'h01900000);
		addEntry("sizeReadZero", opRead, coprocAddr(kBlockPlayer0, kRegSize), 32'h0, 64'h0);

		// Free fall moves y by g*n(n+1)/2 after n ticks
		addEntry("gravity0", opWrite, p0Grav, 32'h1, 64'h0);
		addEntry("gravity1", opWrite, coprocAddr(kBlockPlayer1, kRegGravity), 32'h2, 64'h0);
		addEntry("fallTick1", opTick, 13'd0, 32'h0, 64'h0);
		addEntry("fallSprite1", opSprite, 13'd0, 32'h0, 64'h00140001_00100010);
		addEntry("fallTick2", opTick, 13'd0, 32'h0, 64'h0);
		addEntry("fallTick3", opTick, 13'd0, 32'h0, 64'h0);
		addEntry("fallSprite3", opSprite, 13'd0, 32'h0, 64'h00140006_00100010);
		addEntry("fallSprite3p1", opSprite, 13'd1, 32'h0, 64'h0190000c_00080008);
		addEntry("fallRead0", opRead, p0Grav, 32'h0, 64'h00140006);
		addEntry("fallRead1", opRead, p1Start, 32'h0, 64'h0190000c);

		// Walking while gravity adds 4 then 5 then 6 to y
		addEntry("ctrlRight", opWrite, p0Ctrl, 32'h2, 64'h0);
		addEntry("rightTick1", opTick, 13'd0, 32'h0, 64'h0);
		addEntry("rightTick2", opTick, 13'd0, 32'h0, 64'h0);
		addEntry("rightSprite", opSprite, 13'd0, 32'h0, 64'h001c000f_00100010);
		addEntry("ctrlLeft", opWrite, p0Ctrl, 32'h1, 64'h0);
		addEntry("leftTick", opTick, 13'd0, 32'h0, 64'h0);
		addEntry("leftSprite", opSprite, 13'd0, 32'h0, 64'h00180015_00100010);

		// Landing from (150,180) sets floor once y+16 passes 200
		addEntry("ctrlIdle", opWrite, p0Ctrl, 32'h0, 64'h0);
		addEntry("startAbove", opWrite, p0Start, 32'h009600b4, 64'h0);
		addEntry("dropTick1", opTick, 13'd0, 32'h0, 64'h0);   // y 181
		addEntry("dropTick2", opTick, 13'd0, 32'h0, 64'h0);   // y 183
		addEntry("dropTick3", opTick, 13'd0, 32'h0, 64'h0);   // y 186 and floor
		addEntry("floorContact", opRead, p0Ctrl, 32'h0, 64'h1);
		addEntry("standTick1", opTick, 13'd0, 32'h0, 64'h0);
		addEntry("standSprite1", opSprite, 13'd0, 32'h0, 64'h009600ba_00100010);
		addEntry("standTick2", opTick, 13'd0, 32'h0, 64'h0);
		addEntry("standSprite2", opSprite, 13'd0, 32'h0, 64'h009600ba_00100010);
		addEntry("standContact", opRead, p0Ctrl, 32'h0, 64'h1);
		addEntry("ctrlJump", opWrite, p0Ctrl, 32'h4, 64'h0);
		addEntry("jumpTick", opTick, 13'd0, 32'h0, 64'h0);
		addEntry("jumpSprite", opSprite, 13'd0, 32'h0, 64'h009600ae_00100010);
		addEntry("jumpContact", opRead, p0Ctrl, 32'h0, 64'h0);   // Boxes apart

		addEntry("memReadLate", opRead, 13'h110, 32'h0, spriteWord'(shadow[12'h110]));

		cycleLimit = entryCount * 4 + kResetCycles + kTimeoutMargin;
	endtask

	function automatic logic isControlAddr(busAddr addr);
		return addr[12] && (addr[6:2] == kRegControl) &&
			((addr[11:7] == kBlockPlayer0) || (addr[11:7] == kBlockPlayer1));
	endfunction

	// Drive, capture edge, settle edge, then sample on the falling edge
	task automatic applyEntry(int i);
		@(posedge clock);
		case (opTab[i])
			opWrite: begin
				address <= addrTab[i];
				writeData <= dataTab[i];
				writeEnable <= 1'b1;
			end
			opRead: address <= addrTab[i];
			opTick: frameTick <= 1'b1;
			default: ;
		endcase
		@(posedge clock);
		writeEnable <= 1'b0;
		frameTick <= 1'b0;
		@(posedge clock);
		@(negedge clock);
		if (opTab[i] == opRead) begin
			if (isControlAddr(addrTab[i])) begin
				checkContact(nameTab[i], expTab[i][3:0], readData[3:0]);
				if (readData[31:4] !== '0) begin
					errorCount++;
					$display("error %s expected upper bits 0 actual %h", nameTab[i],
						readData[31:4]);
				end
			end else begin
				checkWord(nameTab[i], expTab[i][31:0], readData);
			end
		end else if (opTab[i] == opSprite) begin
			case (addrTab[i][1:0])
				2'd0: checkSprite(nameTab[i], expTab[i], p1Sprite);
				2'd1: checkSprite(nameTab[i], expTab[i], p2Sprite);
				default: checkSprite(nameTab[i], expTab[i], stageSprite);
			endcase
		end
	endtask

	initial begin
		address = '0;
		writeData = '0;
		writeEnable = 1'b0;
		frameTick = 1'b0;
		buildTable();
		while (reset !== 1'b0) @(posedge clock);
		for (int i = 0; i < entryCount; i++) begin
			applyEntry(i);
		end
		$display("checks %0d errors %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// Run limit from the table length
	initial begin
		@(posedge clock);
		while (cycleCount < cycleLimit) begin
			@(posedge clock);
			cycleCount++;
		end
		$display("run stopped after %0d cycles without reaching the end of the table",
			cycleCount);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== vlog.f ====
source/arenaPkg.sv
source/dataMemory.sv
source/busRegisters.sv
source/physicsStage.sv
source/sceneStage.sv
source/arenaCore.sv
bench/clockGen.sv
bench/arenaTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module arenaTb -f vlog.f -Mdir obj_dir -o arenaSim || exit 1
result=$(./obj_dir/arenaSim)
echo "$result"
echo "$result" | grep -q "ALL TESTS PASSED" && exit 0 || exit 1
